// File: fetch_subsys.f
verilog/fetch_pkg.sv
verilog/dmw_translator.sv
verilog/tlb_fill_ctrl.sv
verilog/tlb_entry.sv
verilog/tlb_hit_select.sv
verilog/if_stage.sv
verilog/fetch_subsys.sv
tb/inst_sram_model.sv
tb/fetch_subsys_tb.sv

// File: Makefile
# Verilator build and run of the fetch subsystem testbench

all: run

obj_dir/Vfetch_subsys_tb: fetch_subsys.f $(wildcard verilog/*.sv tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module fetch_subsys_tb \
		-f fetch_subsys.f

run: obj_dir/Vfetch_subsys_tb
	./obj_dir/Vfetch_subsys_tb | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: tb/fetch_subsys_tb.sv
`timescale 1ns/1ps

module fetch_subsys_tb;
    import fetch_pkg::*;

    localparam int NUM_TESTS  = 10;
    localparam int IDLE_LIMIT = 200;   // cycles allowed without an accepted instruction

    typedef enum logic [2:0] {
        REDIR_NONE,
        REDIR_BRANCH,
        REDIR_EX,
        REDIR_ERTN,
        REDIR_REFETCH,
        REDIR_REFETCH_EX
    } redir_kind_t;

    typedef struct packed {
        logic [31:0]          crmd;
        logic [31:0]          dmw0;
        logic [31:0]          dmw1;
        logic [31:0]          asid;
        logic                 fill;
        logic                 fill_use_index;
        logic [TLB_IDX_W-1:0] fill_index;
        tlb_entry_t           fill_data;
        redir_kind_t          redir;
        logic [31:0]          target;
        logic [7:0]           n_inst;
        logic [2:0]           exp_tlb_exc;   // {refill, page invalid, privilege}
        logic                 crit;
    } scenario_t;

    logic                 clk;
    logic                 reset;
    logic                 ds_allowin;
    br_bus_t              br_bus;
    logic                 fs_to_ds_valid;
    fs_to_ds_t            fs_to_ds;
    logic                 inst_sram_req;
    logic [31:0]          inst_sram_addr;
    logic [31:0]          inst_sram_rdata;
    logic                 inst_sram_addr_ok;
    logic                 inst_sram_data_ok;
    logic                 wb_ex;
    logic                 wb_ertn;
    logic                 wb_refetch;
    logic [31:0]          csr_eentry;
    logic [31:0]          csr_era;
    logic [31:0]          refetch_pc;
    logic                 csr_critical_change;
    logic [31:0]          csr_crmd;
    logic [31:0]          csr_dmw0;
    logic [31:0]          csr_dmw1;
    logic [31:0]          csr_asid;
    logic                 tlb_fill;
    logic                 tlb_fill_use_index;
    logic [TLB_IDX_W-1:0] tlb_fill_index;
    tlb_entry_t           tlb_fill_data;

    scenario_t   scenarios [NUM_TESTS];
    string       names [NUM_TESTS];
    tlb_entry_t  tlb_model [TLB_ENTRIES];
    logic        tlb_model_valid [TLB_ENTRIES];
    int          repl_count;
    logic [31:0] exp_pc;
    int          errors;
    int          checks;

    fetch_subsys u_fetch_subsys (.*);

    inst_sram_model u_inst_sram_model (
        .clk     (clk),
        .reset   (reset),
        .req     (inst_sram_req),
        .addr    (inst_sram_addr),
        .addr_ok (inst_sram_addr_ok),
        .data_ok (inst_sram_data_ok),
        .rdata   (inst_sram_rdata)
    );

    always #2 clk = ~clk;

    task automatic build_table();
        names[0] = "reset_direct";
        scenarios[0] = '{32'h8, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 4'd0, '0,
                         REDIR_NONE, RESET_PC, 8'd40, 3'b000, 1'b0};
        names[1] = "dmw0_window";   // both windows match, window 0 wins
        scenarios[1] = '{32'h0, 32'h8000_0001, 32'h8200_0001, 32'h0, 1'b0, 1'b0, 4'd0, '0,
                         REDIR_BRANCH, 32'h8000_1000, 8'd6, 3'b000, 1'b0};
        names[2] = "dmw1_window";
        scenarios[2] = '{32'h0, 32'h8000_0001, 32'hA200_0001, 32'h0, 1'b0, 1'b0, 4'd0, '0,
                         REDIR_EX, 32'hA000_2000, 8'd6, 3'b000, 1'b0};
        names[3] = "tlb_page_hit";
        scenarios[3] = '{32'h0, 32'h8000_0001, 32'h0, 32'h5, 1'b1, 1'b1, 4'd2,
                         '{20'h00403, 10'h005, 20'h12345, 2'd0, 2'd1, 1'b1, 1'b1},
                         REDIR_ERTN, 32'h0040_3010, 8'd6, 3'b000, 1'b0};
        names[4] = "tlb_refill";
        scenarios[4] = '{32'h0, 32'h8000_0001, 32'h0, 32'h5, 1'b0, 1'b0, 4'd0, '0,
                         REDIR_BRANCH, 32'h0050_0000, 8'd4, 3'b100, 1'b0};
        names[5] = "tlb_page_invalid";   // no index given, lands on entry 0
        scenarios[5] = '{32'h0, 32'h8000_0001, 32'h0, 32'h5, 1'b1, 1'b0, 4'd0,
                         '{20'h00600, 10'h005, 20'h0ABCD, 2'd0, 2'd1, 1'b0, 1'b0},
                         REDIR_BRANCH, 32'h0060_0040, 8'd4, 3'b010, 1'b0};
        names[6] = "tlb_privilege";
        scenarios[6] = '{32'h3, 32'h8000_0001, 32'h0, 32'h5, 1'b1, 1'b1, 4'd7,
                         '{20'h00700, 10'h005, 20'h0F0F0, 2'd0, 2'd1, 1'b1, 1'b1},
                         REDIR_REFETCH, 32'h0070_0100, 8'd4, 3'b001, 1'b0};
        names[7] = "refetch_over_ex";
        scenarios[7] = '{32'h8, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 4'd0, '0,
                         REDIR_REFETCH_EX, 32'h1C00_4000, 8'd6, 3'b000, 1'b1};
        names[8] = "branch_target";
        scenarios[8] = '{32'h8, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 4'd0, '0,
                         REDIR_BRANCH, 32'h1C00_0200, 8'd16, 3'b000, 1'b0};
        names[9] = "misaligned_branch";
        scenarios[9] = '{32'h8, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 4'd0, '0,
                         REDIR_BRANCH, 32'h1C00_0302, 8'd3, 3'b000, 1'b0};
    endtask

    // direct mode, then window 0, window 1, then the page table
    function automatic logic [31:0] expected_phys(input logic [31:0] va, input scenario_t s);
        logic [1:0]  plv;
        logic [31:0] pa;
        plv = s.crmd[1:0];
        pa  = '0;
        if (s.crmd[3])
            pa = va;
        else if (s.dmw0[plv] && s.dmw0[31:29] == va[31:29])
            pa = {s.dmw0[27:25], va[28:0]};
        else if (s.dmw1[plv] && s.dmw1[31:29] == va[31:29])
            pa = {s.dmw1[27:25], va[28:0]};
        else
        begin
            for (int i = 0; i < TLB_ENTRIES; i++)
            begin
                if (tlb_model_valid[i] && tlb_model[i].vpn == va[31:12]
                    && tlb_model[i].asid == s.asid[9:0])
                    pa = {tlb_model[i].ppn, va[11:0]};
            end
        end
        return pa;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            $display("[FAIL] %s: expected %h, actual %h", what, expected, actual);
            errors++;
        end
    endtask

    task automatic drive_fill(input scenario_t s);
        int idx;
        idx = s.fill_use_index ? int'(s.fill_index) : repl_count % TLB_ENTRIES;
        tlb_model[idx]       = s.fill_data;
        tlb_model_valid[idx] = 1'b1;
        if (!s.fill_use_index)
            repl_count++;   // replacement pointer moves
        tlb_fill           = 1'b1;
        tlb_fill_use_index = s.fill_use_index;
        tlb_fill_index     = s.fill_index;
        tlb_fill_data      = s.fill_data;
        @(posedge clk);
        #1;
        tlb_fill = 1'b0;
    endtask

    task automatic start_redirect(input scenario_t s);
        case (s.redir)
            REDIR_BRANCH:
            begin
                br_bus.taken  = 1'b1;
                br_bus.target = s.target;
            end
            REDIR_EX:
            begin
                wb_ex      = 1'b1;
                csr_eentry = s.target;
            end
            REDIR_ERTN:
            begin
                wb_ertn = 1'b1;
                csr_era = s.target;
            end
            REDIR_REFETCH:
            begin
                wb_refetch = 1'b1;
                refetch_pc = s.target;
            end
            REDIR_REFETCH_EX:
            begin
                wb_refetch = 1'b1;
                wb_ex      = 1'b1;
                refetch_pc = s.target;
                csr_eentry = s.target + 32'h100;   // must lose to refetch
            end
            default:
            begin
            end
        endcase
    endtask

    task automatic collect_accepts(input int r);
        scenario_t   s;
        logic [31:0] phys;
        int          count;
        int          idle;
        s     = scenarios[r];
        count = 0;
        idle  = 0;
        while (count < int'(s.n_inst) && idle < IDLE_LIMIT)
        begin
            @(negedge clk);   // outputs settled mid cycle
            if (fs_to_ds_valid && ds_allowin)
            begin
                phys = expected_phys(exp_pc, s);
                compare_value({names[r], " pc"}, exp_pc, fs_to_ds.pc);
                if (!s.exp_tlb_exc[2])   // refill has no defined address
                    compare_value({names[r], " inst"}, ~phys, fs_to_ds.inst);
                compare_value({names[r], " adef"}, 32'(exp_pc[1:0] != 2'b00),
                              32'(fs_to_ds.adef));
                compare_value({names[r], " tlb_exc"}, 32'(s.exp_tlb_exc),
                              32'(fs_to_ds.tlb_exc));
                compare_value({names[r], " refetch"}, 32'(s.crit), 32'(fs_to_ds.refetch));
                exp_pc = exp_pc + 32'd4;
                count++;
                idle = 0;
            end
            else
                idle++;
            @(posedge clk);
            #1;
            ds_allowin = ($urandom % 4) != 0;   // random decode stalls
        end
        if (count < int'(s.n_inst))
        begin
            $display("timeout: decode got only %0d of %0d instructions in %s",
                     count, s.n_inst, names[r]);
            errors++;
        end
    endtask

    initial
    begin
        int row_errors;
        void'($urandom(32'h88714187));
        build_table();
        clk                 = 1'b0;
        reset               = 1'b1;
        ds_allowin          = 1'b0;
        br_bus              = '0;
        wb_ex               = 1'b0;
        wb_ertn             = 1'b0;
        wb_refetch          = 1'b0;
        csr_eentry          = '0;
        csr_era             = '0;
        refetch_pc          = '0;
        csr_critical_change = scenarios[0].crit;
        csr_crmd            = scenarios[0].crmd;
        csr_dmw0            = scenarios[0].dmw0;
        csr_dmw1            = scenarios[0].dmw1;
        csr_asid            = scenarios[0].asid;
        tlb_fill            = 1'b0;
        tlb_fill_use_index  = 1'b0;
        tlb_fill_index      = '0;
        tlb_fill_data       = '0;
        for (int i = 0; i < TLB_ENTRIES; i++)
        begin
            tlb_model[i]       = '0;
            tlb_model_valid[i] = 1'b0;
        end
        repl_count = 0;
        errors     = 0;
        checks     = 0;
        exp_pc     = RESET_PC;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int r = 0; r < NUM_TESTS; r++)
        begin
            row_errors = errors;
            ds_allowin = 1'b0;   // hold decode while the mode changes
            if (scenarios[r].fill)
                drive_fill(scenarios[r]);
            csr_crmd            = scenarios[r].crmd;
            csr_dmw0            = scenarios[r].dmw0;
            csr_dmw1            = scenarios[r].dmw1;
            csr_asid            = scenarios[r].asid;
            csr_critical_change = scenarios[r].crit;
            if (scenarios[r].redir != REDIR_NONE)
            begin
                start_redirect(scenarios[r]);
                exp_pc = scenarios[r].target;
                @(posedge clk);
                #1;
                br_bus.taken = 1'b0;
                wb_ex        = 1'b0;
                wb_ertn      = 1'b0;
                wb_refetch   = 1'b0;
            end
            ds_allowin = 1'b1;
            collect_accepts(r);
            $display("%s: %0d instructions, %0d mismatches", names[r],
                     scenarios[r].n_inst, errors - row_errors);
        end

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: tb/inst_sram_model.sv
`timescale 1ns/1ps

module inst_sram_model (
    input  logic        clk,
    input  logic        reset,
    input  logic        req,
    input  logic [31:0] addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata
);
    logic        busy;        // one request accepted, answer still owed
    logic [1:0]  delay;
    logic [31:0] held_addr;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            addr_ok   <= 1'b0;
            data_ok   <= 1'b0;
            busy      <= 1'b0;
            delay     <= '0;
            held_addr <= '0;
            rdata     <= '0;
        end
        else
        begin
            data_ok <= 1'b0;
            rdata   <= $urandom;   // garbage outside the data_ok cycle
            if (busy)
            begin
                if (delay == 2'd0)
                begin
                    data_ok <= 1'b1;
                    rdata   <= ~held_addr;   // word is the inverted physical address
                    busy    <= 1'b0;
                    addr_ok <= ($urandom % 4) != 0;
                end
                else
                    delay <= delay - 2'd1;
            end
            else if (req && addr_ok)
            begin
                held_addr <= addr;
                delay     <= 2'($urandom % 4);   // data_ok 1 to 4 cycles later
                busy      <= 1'b1;
                addr_ok   <= 1'b0;
            end
            else
                addr_ok <= ($urandom % 4) != 0;
        end
    end

endmodule

// File: verilog/fetch_subsys.sv
`timescale 1ns/1ps

module fetch_subsys (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            ds_allowin,
    input  fetch_pkg::br_bus_t              br_bus,
    output logic                            fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t            fs_to_ds,
    output logic                            inst_sram_req,
    output logic [31:0]                     inst_sram_addr,
    input  logic [31:0]                     inst_sram_rdata,
    input  logic                            inst_sram_addr_ok,
    input  logic                            inst_sram_data_ok,
    input  logic                            wb_ex,
    input  logic                            wb_ertn,
    input  logic                            wb_refetch,
    input  logic [31:0]                     csr_eentry,
    input  logic [31:0]                     csr_era,
    input  logic [31:0]                     refetch_pc,
    input  logic                            csr_critical_change,
    input  logic [31:0]                     csr_crmd,
    input  logic [31:0]                     csr_dmw0,
    input  logic [31:0]                     csr_dmw1,
    input  logic [31:0]                     csr_asid,
    input  logic                            tlb_fill,
    input  logic                            tlb_fill_use_index,
    input  logic [fetch_pkg::TLB_IDX_W-1:0] tlb_fill_index,
    input  fetch_pkg::tlb_entry_t           tlb_fill_data
);
    import fetch_pkg::*;

    tlb_key_t               tlb_key;
    tlb_result_t            tlb_result;
    logic [TLB_ENTRIES-1:0] entry_we;
    logic [TLB_ENTRIES-1:0] entry_hit;
    tlb_entry_t             entry_stored [TLB_ENTRIES];

    // port names match the top level one to one
    if_stage u_if_stage (.*);

    tlb_fill_ctrl u_tlb_fill_ctrl (
        .clk                (clk),
        .reset              (reset),
        .tlb_fill           (tlb_fill),
        .tlb_fill_use_index (tlb_fill_use_index),
        .tlb_fill_index     (tlb_fill_index),
        .entry_we           (entry_we)
    );

    for (genvar i = 0; i < TLB_ENTRIES; i++)
    begin : g_tlb
        tlb_entry u_tlb_entry (
            .clk       (clk),
            .reset     (reset),
            .we        (entry_we[i]),
            .fill_data (tlb_fill_data),
            .key       (tlb_key),
            .hit       (entry_hit[i]),
            .stored    (entry_stored[i])
        );
    end

    tlb_hit_select u_tlb_hit_select (
        .hit     (entry_hit),
        .entries (entry_stored),
        .result  (tlb_result)
    );

endmodule

// File: verilog/if_stage.sv
`timescale 1ns/1ps

module if_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ds_allowin,
    input  fetch_pkg::br_bus_t     br_bus,
    output logic                   fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t   fs_to_ds,
    output logic                   inst_sram_req,
    output logic [31:0]            inst_sram_addr,
    input  logic [31:0]            inst_sram_rdata,
    input  logic                   inst_sram_addr_ok,
    input  logic                   inst_sram_data_ok,
    input  logic                   wb_ex,
    input  logic                   wb_ertn,
    input  logic                   wb_refetch,
    input  logic [31:0]            csr_eentry,
    input  logic [31:0]            csr_era,
    input  logic [31:0]            refetch_pc,
    input  logic                   csr_critical_change,
    input  logic [31:0]            csr_crmd,
    input  logic [31:0]            csr_dmw0,
    input  logic [31:0]            csr_dmw1,
    input  logic [31:0]            csr_asid,
    output fetch_pkg::tlb_key_t    tlb_key,
    input  fetch_pkg::tlb_result_t tlb_result
);
    import fetch_pkg::*;

    fetch_state_t state;
    fetch_state_t state_nxt;

    logic [31:0] fs_pc;           // pc of the request in flight or last returned
    logic [31:0] seq_pc;
    logic [31:0] nextpc;
    logic [31:0] nextpc_r;        // held redirect target
    logic [31:0] redirect_target;
    logic        wb_any;
    logic        br_taken;
    logic        redirect;
    logic        in_wait;
    logic        fs_free;
    logic        handshake;

    logic [31:0] inst_buf;
    logic        buf_valid;

    logic [31:0] dmw_addr;
    logic        use_page_table;
    logic [2:0]  tlb_exc;
    logic [2:0]  fs_tlb_exc;
    logic        fs_adef;

    assign wb_any   = wb_refetch | wb_ex | wb_ertn;
    assign br_taken = br_bus.taken & ~br_bus.stall;
    assign redirect = wb_any | br_taken;

    // refetch > exception > return > branch
    always_comb
    begin
        if (wb_refetch)
            redirect_target = refetch_pc;
        else if (wb_ex)
            redirect_target = csr_eentry;
        else if (wb_ertn)
            redirect_target = csr_era;
        else
            redirect_target = br_bus.target;
    end

    assign seq_pc  = fs_pc + 32'd4;   // one word per fetch
    assign nextpc  = redirect                 ? redirect_target :
                     (state == FETCH_REQ_BR)  ? nextpc_r        : seq_pc;

    assign in_wait = (state == FETCH_WAIT) || (state == FETCH_WAIT_BR);
    assign fs_free = ~buf_valid | ds_allowin | redirect;  // buffered word leaves or is dropped

    always_comb
    begin
        case (state)
            FETCH_REQ:    inst_sram_req = fs_free & (~br_bus.stall | wb_any);
            FETCH_REQ_BR: inst_sram_req = 1'b1;
            default:      inst_sram_req = 1'b0;
        endcase
    end

    assign handshake = inst_sram_req & inst_sram_addr_ok;

    always_comb
    begin
        state_nxt = state;
        case (state)
            FETCH_REQ, FETCH_REQ_BR:
            begin
                if (handshake)
                    state_nxt = (redirect || state == FETCH_REQ_BR) ? FETCH_WAIT_BR
                                                                    : FETCH_WAIT;
                else if (redirect)
                    state_nxt = FETCH_REQ_BR;
            end
            FETCH_WAIT, FETCH_WAIT_BR:
            begin
                if (redirect)
                    state_nxt = inst_sram_data_ok ? FETCH_REQ_BR : FETCH_DROP;
                else if (inst_sram_data_ok)
                    state_nxt = FETCH_REQ;
            end
            FETCH_DROP:
            begin
                if (inst_sram_data_ok)   // old response gone, fetch the target
                    state_nxt = FETCH_REQ_BR;
            end
            default:
                state_nxt = FETCH_REQ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= FETCH_REQ;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk)
    begin
        if (redirect)
            nextpc_r <= redirect_target;  // a newer redirect replaces the older one
    end

    // first sequential pc after reset lands on RESET_PC
    always_ff @(posedge clk)
    begin
        if (reset)
            fs_pc <= RESET_PC - 32'd4;
        else if (handshake)
            fs_pc <= nextpc;
    end

    // flags travel with the request they were computed for
    always_ff @(posedge clk)
    begin
        if (handshake)
        begin
            fs_adef    <= nextpc[1:0] != 2'b00;
            fs_tlb_exc <= use_page_table ? tlb_exc : 3'b000;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            buf_valid <= 1'b0;
        else if (redirect || ds_allowin)
            buf_valid <= 1'b0;
        else if (in_wait && inst_sram_data_ok)
            buf_valid <= 1'b1;   // decode stalled on a returned word
    end

    always_ff @(posedge clk)
    begin
        if (in_wait && inst_sram_data_ok)
            inst_buf <= inst_sram_rdata;
    end

    assign fs_to_ds_valid = ((in_wait & inst_sram_data_ok) | buf_valid) & ~redirect;

    always_comb
    begin
        fs_to_ds.tlb_exc = fs_tlb_exc;
        fs_to_ds.refetch = csr_critical_change;
        fs_to_ds.adef    = fs_adef;
        fs_to_ds.inst    = buf_valid ? inst_buf : inst_sram_rdata;
        fs_to_ds.pc      = fs_pc;
    end

    dmw_translator u_dmw_translator (
        .va             (nextpc),
        .csr_crmd       (csr_crmd),
        .csr_dmw0       (csr_dmw0),
        .csr_dmw1       (csr_dmw1),
        .phys_addr      (dmw_addr),
        .use_page_table (use_page_table)
    );

    assign tlb_key.asid = csr_asid[9:0];
    assign tlb_key.vpn  = nextpc[31:12];

    assign inst_sram_addr = use_page_table ? {tlb_result.ppn, nextpc[11:0]} : dmw_addr;

    assign tlb_exc[2] = ~tlb_result.found;                        // refill
    assign tlb_exc[1] = tlb_result.found & ~tlb_result.v;         // page invalid
    assign tlb_exc[0] = tlb_result.found & tlb_result.v
                      & (csr_crmd[1:0] > tlb_result.plv);         // privilege

    // one request in flight at most
    a_no_req_busy: assert property (@(posedge clk) disable iff (reset)
        (state inside {FETCH_WAIT, FETCH_WAIT_BR, FETCH_DROP}) |-> !inst_sram_req);

    // a stale word is never handed to decode
    a_drop_silent: assert property (@(posedge clk) disable iff (reset)
        (state == FETCH_DROP) |-> !fs_to_ds_valid);

endmodule

// File: verilog/tlb_hit_select.sv
`timescale 1ns/1ps

module tlb_hit_select (
    input  logic [fetch_pkg::TLB_ENTRIES-1:0] hit,
    input  fetch_pkg::tlb_entry_t             entries [fetch_pkg::TLB_ENTRIES],
    output fetch_pkg::tlb_result_t            result
);
    import fetch_pkg::*;

    logic [TLB_IDX_W-1:0] hit_idx;
    tlb_entry_t           sel;

    // scan downward so the lowest numbered hit is left in hit_idx
    always_comb
    begin
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--)
        begin
            if (hit[i])
                hit_idx = TLB_IDX_W'(i);
        end
    end

    assign sel = entries[hit_idx];

    always_comb
    begin
        result.found = |hit;
        result.index = hit_idx;
        result.ppn   = sel.ppn;
        result.plv   = sel.plv;
        result.mat   = sel.mat;
        result.d     = sel.d;
        result.v     = sel.v;
    end

    // duplicate mappings for one key would make the lookup ambiguous
    always_comb
    begin
        a_single_hit: assert ($isunknown(hit) || $onehot0(hit))
            else $error("tlb: several entries hit the same key");
    end

endmodule

// File: verilog/tlb_entry.sv
`timescale 1ns/1ps

module tlb_entry (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  fetch_pkg::tlb_entry_t fill_data,
    input  fetch_pkg::tlb_key_t   key,
    output logic                  hit,
    output fetch_pkg::tlb_entry_t stored
);
    logic present;

    always_ff @(posedge clk)
    begin
        if (reset)
            present <= 1'b0;
        else if (we)
            present <= 1'b1;
    end

    // mapping itself, only meaningful once present
    always_ff @(posedge clk)
    begin
        if (we)
            stored <= fill_data;
    end

    // 4 KB page only, so vpn includes va bit 12
    assign hit = present
              && (stored.vpn == key.vpn)
              && (stored.asid == key.asid);

endmodule

// File: verilog/tlb_fill_ctrl.sv
`timescale 1ns/1ps

module tlb_fill_ctrl (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            tlb_fill,
    input  logic                            tlb_fill_use_index,
    input  logic [fetch_pkg::TLB_IDX_W-1:0] tlb_fill_index,
    output logic [fetch_pkg::TLB_ENTRIES-1:0] entry_we
);
    import fetch_pkg::*;

    logic [TLB_IDX_W-1:0] repl_ptr;
    logic [TLB_IDX_W-1:0] fill_idx;

    // round robin victim for fills without an explicit index
    always_ff @(posedge clk)
    begin
        if (reset)
            repl_ptr <= '0;
        else if (tlb_fill && !tlb_fill_use_index)
            repl_ptr <= repl_ptr + 1'b1;
    end

    assign fill_idx = tlb_fill_use_index ? tlb_fill_index : repl_ptr;

    always_comb
    begin
        entry_we = '0;
        if (tlb_fill)
            entry_we[fill_idx] = 1'b1;
    end

    // never more than one entry written per fill
    a_we_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(entry_we) && (tlb_fill == (entry_we != '0)));

endmodule

// File: verilog/dmw_translator.sv
`timescale 1ns/1ps

module dmw_translator (
    input  logic [31:0] va,
    input  logic [31:0] csr_crmd,
    input  logic [31:0] csr_dmw0,
    input  logic [31:0] csr_dmw1,
    output logic [31:0] phys_addr,
    output logic        use_page_table
);
    logic [1:0] plv;
    logic       da;
    logic       dmw0_hit;
    logic       dmw1_hit;

    // window enabled for this plv and segment matches
    function automatic logic window_hit(input logic [31:0] dmw, input logic [1:0] cur_plv,
                                        input logic [2:0] vseg);
        logic plv_ok;
        plv_ok = (cur_plv == 2'd0 && dmw[0]) || (cur_plv == 2'd3 && dmw[3]);
        return plv_ok && (dmw[31:29] == vseg);
    endfunction

    assign plv = csr_crmd[1:0];
    assign da  = csr_crmd[3];   // direct address mode

    assign dmw0_hit = window_hit(csr_dmw0, plv, va[31:29]);
    assign dmw1_hit = window_hit(csr_dmw1, plv, va[31:29]);

    always_comb
    begin
        if (da)
            phys_addr = va;
        else if (dmw0_hit)
            phys_addr = {csr_dmw0[27:25], va[28:0]};   // window 0 first
        else if (dmw1_hit)
            phys_addr = {csr_dmw1[27:25], va[28:0]};
        else
            phys_addr = va;   // overridden by tlb path
    end

    assign use_page_table = !da && !dmw0_hit && !dmw1_hit;

endmodule

// File: verilog/fetch_pkg.sv
package fetch_pkg;

    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W = 4;
    localparam logic [31:0] RESET_PC = 32'h1C00_0000;
    localparam logic [1:0] SRAM_SIZE_WORD = 2'b10;  // 0: byte, 1: half, 2: word

    typedef enum logic [2:0] {
        FETCH_REQ,      // sequential request
        FETCH_WAIT,     // sequential data pending
        FETCH_WAIT_BR,  // redirect target data pending
        FETCH_REQ_BR,   // redirect target not yet accepted by sram
        FETCH_DROP      // stale response still to come
    } fetch_state_t;

    typedef struct packed {
        logic        stall;
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

    // tlb_exc order is {refill, page invalid, privilege}
    typedef struct packed {
        logic [2:0]  tlb_exc;
        logic        refetch;
        logic        adef;
        logic [31:0] inst;
        logic [31:0] pc;
    } fs_to_ds_t;

    typedef struct packed {
        logic [19:0] vpn;   // vppn plus va bit 12
        logic [9:0]  asid;
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_entry_t;

    typedef struct packed {
        logic [9:0]  asid;
        logic [19:0] vpn;
    } tlb_key_t;

    typedef struct packed {
        logic                 found;
        logic [TLB_IDX_W-1:0] index;
        logic [19:0]          ppn;
        logic [1:0]           plv;
        logic [1:0]           mat;
        logic                 d;
        logic                 v;
    } tlb_result_t;

endpackage
